// ==== rtl/wg_params.svh ====
`ifndef WG_PARAMS_SVH
`define WG_PARAMS_SVH

// Number of transaction slots tracked at once
`define WG_MAX_TXNS 4

// Observed AXI field widths
`define WG_ID_WIDTH 4
`define WG_ADDR_WIDTH 16
`define WG_LEN_WIDTH 4

// Cycle counters and budgets
`define WG_CNT_WIDTH 10

`endif

// ==== rtl/wg_axi_pkg.sv ====
`include "wg_params.svh"

package wg_axi_pkg;

  // AW and B transaction ID
  typedef logic [`WG_ID_WIDTH-1:0] axi_id_t;

  // Write address as seen on AW
  typedef logic [`WG_ADDR_WIDTH-1:0] axi_addr_t;

  // Burst length, beats minus one
  typedef logic [`WG_LEN_WIDTH-1:0] axi_len_t;

endpackage

// ==== rtl/wg_guard_pkg.sv ====
`include "wg_params.svh"

package wg_guard_pkg;

  // Index into the slot tables
  typedef logic [$clog2(`WG_MAX_TXNS)-1:0] slot_idx_t;

  // Cycle counter, also used for budgets
  typedef logic [`WG_CNT_WIDTH-1:0] cnt_t;

  // Life of one slot
  typedef enum logic [1:0] {
    WS_IDLE,
    WS_DATA,
    WS_RESP,
    WS_FAULT
  } write_state_e;

  // Lower value wins when several faults show up together
  typedef enum logic [2:0] {
    FAULT_NONE,
    FAULT_TABLE_FULL,
    FAULT_UNWANTED_B,
    FAULT_AW_STALL,
    FAULT_W_TIMEOUT,
    FAULT_B_TIMEOUT
  } fault_cause_e;

endpackage

// ==== rtl/wg_slot_if.sv ====
`timescale 1ns/1ps

interface wg_slot_if;
  import wg_guard_pkg::*;

  // Allocation on an AW handshake
  logic      alloc_valid;
  slot_idx_t alloc_idx;
  logic      overflow;

  // Head slot for the ID of the current B handshake
  logic      rsp_hit;
  slot_idx_t rsp_idx;

  // Completed slot going back to the free pool
  logic      release_valid;
  slot_idx_t release_idx;

  modport queue (
    output alloc_valid, alloc_idx, overflow, rsp_hit, rsp_idx,
    input  release_valid, release_idx
  );

  modport tracker (
    input  alloc_valid, alloc_idx, overflow, rsp_hit, rsp_idx,
    output release_valid, release_idx
  );

endinterface

// ==== rtl/wg_id_queue.sv ====
`timescale 1ns/1ps
`include "wg_params.svh"

module wg_id_queue (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                flush_i,
  input  logic                aw_valid_i,
  input  logic                aw_ready_i,
  input  wg_axi_pkg::axi_id_t aw_id_i,
  input  logic                b_valid_i,
  input  logic                b_ready_i,
  input  wg_axi_pkg::axi_id_t b_id_i,
  wg_slot_if.queue            slot_if
);
  import wg_axi_pkg::*;
  import wg_guard_pkg::*;

  localparam int unsigned NumSlots = `WG_MAX_TXNS;

  // One head-tail entry per ID in flight
  typedef struct packed {
    logic      valid;
    axi_id_t   id;
    slot_idx_t head;
    slot_idx_t tail;
  } ht_entry_t;

  ht_entry_t [NumSlots-1:0] ht_q, ht_d;
  slot_idx_t [NumSlots-1:0] next_q, next_d;
  logic      [NumSlots-1:0] used_q, used_d;
  logic      [NumSlots-1:0] rel_hit;
  logic      [NumSlots-1:0] rsp_match;

  logic      aw_hs;
  logic      slot_found;
  logic      id_found;
  slot_idx_t free_slot;
  slot_idx_t free_ht;
  slot_idx_t id_ht;

  assign aw_hs = aw_valid_i && aw_ready_i;

  for (genvar i = 0; i < NumSlots; i++) begin : gen_match
    assign rel_hit[i]   = ht_q[i].valid && (ht_q[i].head == slot_if.release_idx);
    assign rsp_match[i] = ht_q[i].valid && (ht_q[i].id == b_id_i);
  end

  always_comb begin
    ht_d       = ht_q;
    next_d     = next_q;
    used_d     = used_q;
    slot_found = 1'b0;
    free_slot  = '0;
    free_ht    = '0;
    id_found   = 1'b0;
    id_ht      = '0;

    // Release goes first so the freed slot is usable by an AW in the same cycle
    if (slot_if.release_valid) begin
      used_d[slot_if.release_idx] = 1'b0;
      for (int i = 0; i < NumSlots; i++) begin
        if (rel_hit[i]) begin
          if (ht_q[i].head == ht_q[i].tail) begin
            ht_d[i].valid = 1'b0;
          end else begin
            ht_d[i].head = next_q[ht_q[i].head];
          end
        end
      end
    end

    // Walk downwards so the lowest free index wins
    for (int i = NumSlots - 1; i >= 0; i--) begin
      if (!used_d[i]) begin
        slot_found = 1'b1;
        free_slot  = slot_idx_t'(i);
      end
      if (!ht_d[i].valid) begin
        free_ht = slot_idx_t'(i);
      end
      if (ht_d[i].valid && (ht_d[i].id == aw_id_i)) begin
        id_found = 1'b1;
        id_ht    = slot_idx_t'(i);
      end
    end

    if (aw_hs && slot_found) begin
      used_d[free_slot] = 1'b1;
      if (id_found) begin
        // Known ID, append behind its tail
        next_d[ht_d[id_ht].tail] = free_slot;
        ht_d[id_ht].tail         = free_slot;
      end else begin
        ht_d[free_ht] = '{valid: 1'b1, id: aw_id_i, head: free_slot, tail: free_slot};
      end
    end
  end

  assign slot_if.alloc_valid = aw_hs && slot_found;
  assign slot_if.alloc_idx   = free_slot;
  assign slot_if.overflow    = aw_hs && !slot_found;
  assign slot_if.rsp_hit     = b_valid_i && b_ready_i && (|rsp_match);

  // Responses always complete the oldest slot of their ID
  always_comb begin
    slot_if.rsp_idx = '0;
    for (int i = 0; i < NumSlots; i++) begin
      if (rsp_match[i]) begin
        slot_if.rsp_idx = ht_q[i].head;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ht_q   <= '0;
      used_q <= '0;
    end else if (flush_i) begin
      ht_q   <= '0;
      used_q <= '0;
    end else begin
      ht_q   <= ht_d;
      used_q <= used_d;
    end
  end

  // Next pointers are only followed from slots in use
  always_ff @(posedge clk_i) begin
    next_q <= next_d;
  end

  // The tracker must complete slots in per-ID order
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    slot_if.release_valid |-> (|rel_hit))
    else $error("released slot %0d is not the head of its ID", slot_if.release_idx);

endmodule

// ==== rtl/wg_w_order_fifo.sv ====
`timescale 1ns/1ps
`include "wg_params.svh"

module wg_w_order_fifo #(
  parameter int unsigned Depth = `WG_MAX_TXNS
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    flush_i,
  input  logic                    push_i,
  input  wg_guard_pkg::slot_idx_t push_idx_i,
  input  logic                    pop_i,
  output wg_guard_pkg::slot_idx_t w_slot_o,
  output logic                    w_slot_valid_o
);
  import wg_guard_pkg::*;

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;

  slot_idx_t           mem_q [Depth];
  logic [PtrWidth-1:0] wr_ptr_q, rd_ptr_q;
  logic [PtrWidth:0]   count_q;
  logic                full;

  // Wraps for depths that are not a power of two
  function automatic logic [PtrWidth-1:0] ptr_inc(input logic [PtrWidth-1:0] ptr);
    return (ptr == PtrWidth'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full           = (count_q == (PtrWidth + 1)'(Depth));
  assign w_slot_valid_o = (count_q != '0);
  assign w_slot_o       = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_idx_i;
    end
  end

  // The queue only hands out free slots, so the order FIFO cannot overrun
  assert property (@(posedge clk_i) disable iff (!rst_ni) push_i |-> !full)
    else $error("push into full W order FIFO");

endmodule

// ==== rtl/wg_slot_tracker.sv ====
`timescale 1ns/1ps
`include "wg_params.svh"

module wg_slot_tracker (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       flush_i,
  input  logic                       aw_valid_i,
  input  logic                       aw_ready_i,
  input  wg_axi_pkg::axi_addr_t      aw_addr_i,
  input  wg_axi_pkg::axi_len_t       aw_len_i,
  input  logic                       w_valid_i,
  input  logic                       w_ready_i,
  input  logic                       w_last_i,
  input  logic                       b_valid_i,
  input  logic                       b_ready_i,
  input  wg_guard_pkg::slot_idx_t    w_slot_i,
  input  logic                       w_slot_valid_i,
  input  wg_guard_pkg::cnt_t         budget_aw_i,
  input  wg_guard_pkg::cnt_t         budget_w_beat_i,
  input  wg_guard_pkg::cnt_t         budget_b_i,
  wg_slot_if.tracker                 slot_if,
  output logic                       fault_o,
  output wg_guard_pkg::fault_cause_e fault_cause_o,
  output wg_axi_pkg::axi_addr_t      fault_addr_o
);
  import wg_axi_pkg::*;
  import wg_guard_pkg::*;

  localparam int unsigned NumSlots = `WG_MAX_TXNS;

  write_state_e  state_q  [NumSlots];
  cnt_t          cnt_q    [NumSlots];
  cnt_t          budget_q [NumSlots];
  axi_addr_t     addr_q   [NumSlots];
  logic [NumSlots-1:0] w_to, b_to;

  cnt_t      stall_cnt_q;
  cnt_t      data_budget;
  logic      w_last_hs;
  logic      b_hs;
  logic      unwanted_b;
  logic      aw_stall;
  logic      w_to_any, b_to_any;
  slot_idx_t w_to_idx, b_to_idx;

  // W budget scales with the number of beats in the burst
  assign data_budget = budget_w_beat_i * (cnt_t'(aw_len_i) + cnt_t'(1));

  assign w_last_hs = w_valid_i && w_ready_i && w_last_i;
  assign b_hs      = b_valid_i && b_ready_i;

  assign slot_if.release_valid = slot_if.rsp_hit && (state_q[slot_if.rsp_idx] == WS_RESP);
  assign slot_if.release_idx   = slot_if.rsp_idx;

  assign unwanted_b = b_hs && (!slot_if.rsp_hit || (state_q[slot_if.rsp_idx] != WS_RESP));
  assign aw_stall   = aw_valid_i && !aw_ready_i && (stall_cnt_q == budget_aw_i);

  // Consecutive cycles of AW valid without ready
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stall_cnt_q <= '0;
    end else if (flush_i || !aw_valid_i || aw_ready_i) begin
      stall_cnt_q <= '0;
    end else begin
      stall_cnt_q <= stall_cnt_q + 1'b1;
    end
  end

  for (genvar i = 0; i < NumSlots; i++) begin : gen_slot
    logic alloc_hit, w_done_hit, rel_hit;

    assign alloc_hit  = slot_if.alloc_valid && (slot_if.alloc_idx == slot_idx_t'(i));
    assign w_done_hit = w_last_hs && w_slot_valid_i && (w_slot_i == slot_idx_t'(i));
    assign rel_hit    = slot_if.release_valid && (slot_if.release_idx == slot_idx_t'(i));
    assign w_to[i]    = (state_q[i] == WS_DATA) && (cnt_q[i] == budget_q[i]);
    assign b_to[i]    = (state_q[i] == WS_RESP) && (cnt_q[i] == budget_b_i);

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        state_q[i] <= WS_IDLE;
        cnt_q[i]   <= '0;
      end else if (flush_i) begin
        state_q[i] <= WS_IDLE;
        cnt_q[i]   <= '0;
      end else if (alloc_hit) begin
        state_q[i] <= WS_DATA;
        cnt_q[i]   <= '0;
      end else begin
        case (state_q[i])
          WS_DATA: begin
            if (w_done_hit) begin
              state_q[i] <= WS_RESP;
              cnt_q[i]   <= '0;
            end else begin
              cnt_q[i] <= cnt_q[i] + 1'b1;
              if (w_to[i]) begin
                state_q[i] <= WS_FAULT;
              end
            end
          end
          WS_RESP: begin
            if (rel_hit) begin
              state_q[i] <= WS_IDLE;
              cnt_q[i]   <= '0;
            end else begin
              cnt_q[i] <= cnt_q[i] + 1'b1;
              if (b_to[i]) begin
                state_q[i] <= WS_FAULT;
              end
            end
          end
          // Idle and faulted slots hold their counter
          default: ;
        endcase
      end
    end

    always_ff @(posedge clk_i) begin
      if (alloc_hit) begin
        addr_q[i]   <= aw_addr_i;
        budget_q[i] <= data_budget;
      end
    end
  end

  always_comb begin
    w_to_any      = 1'b0;
    w_to_idx      = '0;
    b_to_any      = 1'b0;
    b_to_idx      = '0;
    fault_cause_o = FAULT_NONE;
    fault_addr_o  = '0;

    // Lowest timed-out slot wins
    for (int i = NumSlots - 1; i >= 0; i--) begin
      if (w_to[i]) begin
        w_to_any = 1'b1;
        w_to_idx = slot_idx_t'(i);
      end
      if (b_to[i]) begin
        b_to_any = 1'b1;
        b_to_idx = slot_idx_t'(i);
      end
    end

    if (slot_if.overflow) begin
      fault_cause_o = FAULT_TABLE_FULL;
      fault_addr_o  = aw_addr_i;
    end else if (unwanted_b) begin
      fault_cause_o = FAULT_UNWANTED_B;
    end else if (aw_stall) begin
      fault_cause_o = FAULT_AW_STALL;
      fault_addr_o  = aw_addr_i;
    end else if (w_to_any) begin
      fault_cause_o = FAULT_W_TIMEOUT;
      fault_addr_o  = addr_q[w_to_idx];
    end else if (b_to_any) begin
      fault_cause_o = FAULT_B_TIMEOUT;
      fault_addr_o  = addr_q[b_to_idx];
    end
  end

  assign fault_o = (fault_cause_o != FAULT_NONE);

  // Any slot the queue returns for a response must be one this tracker holds in use
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    slot_if.rsp_hit |-> (state_q[slot_if.rsp_idx] != WS_IDLE))
    else $error("response lookup names idle slot %0d", slot_if.rsp_idx);

endmodule

// ==== rtl/write_guard.sv ====
`timescale 1ns/1ps

module write_guard (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       aw_valid_i,
  input  logic                       aw_ready_i,
  input  wg_axi_pkg::axi_id_t        aw_id_i,
  input  wg_axi_pkg::axi_addr_t      aw_addr_i,
  input  wg_axi_pkg::axi_len_t       aw_len_i,
  input  logic                       w_valid_i,
  input  logic                       w_ready_i,
  input  logic                       w_last_i,
  input  logic                       b_valid_i,
  input  logic                       b_ready_i,
  input  wg_axi_pkg::axi_id_t        b_id_i,
  input  wg_guard_pkg::cnt_t         budget_aw_i,
  input  wg_guard_pkg::cnt_t         budget_w_beat_i,
  input  wg_guard_pkg::cnt_t         budget_b_i,
  input  logic                       reset_clear_i,
  output logic                       irq_o,
  output logic                       reset_req_o,
  output wg_guard_pkg::fault_cause_e fault_cause_o,
  output wg_axi_pkg::axi_addr_t      fault_addr_o
);
  import wg_axi_pkg::*;
  import wg_guard_pkg::*;

  wg_slot_if slot_if ();

  slot_idx_t    w_slot;
  logic         w_slot_valid;
  logic         w_pop;
  logic         fault;
  fault_cause_e fault_cause;
  axi_addr_t    fault_addr;
  logic         latched_q;
  fault_cause_e cause_q;
  axi_addr_t    addr_q;

  // Last beat retires the oldest burst, stray beats are dropped
  assign w_pop = w_valid_i && w_ready_i && w_last_i && w_slot_valid;

  wg_id_queue i_id_queue (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .flush_i    (reset_clear_i),
    .aw_valid_i (aw_valid_i),
    .aw_ready_i (aw_ready_i),
    .aw_id_i    (aw_id_i),
    .b_valid_i  (b_valid_i),
    .b_ready_i  (b_ready_i),
    .b_id_i     (b_id_i),
    .slot_if    (slot_if.queue)
  );

  wg_w_order_fifo i_w_order_fifo (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (reset_clear_i),
    .push_i         (slot_if.alloc_valid),
    .push_idx_i     (slot_if.alloc_idx),
    .pop_i          (w_pop),
    .w_slot_o       (w_slot),
    .w_slot_valid_o (w_slot_valid)
  );

  wg_slot_tracker i_slot_tracker (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (reset_clear_i),
    .aw_valid_i      (aw_valid_i),
    .aw_ready_i      (aw_ready_i),
    .aw_addr_i       (aw_addr_i),
    .aw_len_i        (aw_len_i),
    .w_valid_i       (w_valid_i),
    .w_ready_i       (w_ready_i),
    .w_last_i        (w_last_i),
    .b_valid_i       (b_valid_i),
    .b_ready_i       (b_ready_i),
    .w_slot_i        (w_slot),
    .w_slot_valid_i  (w_slot_valid),
    .budget_aw_i     (budget_aw_i),
    .budget_w_beat_i (budget_w_beat_i),
    .budget_b_i      (budget_b_i),
    .slot_if         (slot_if.tracker),
    .fault_o         (fault),
    .fault_cause_o   (fault_cause),
    .fault_addr_o    (fault_addr)
  );

  // Sticky fault record, only the first fault after a clear is kept
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      latched_q <= 1'b0;
      cause_q   <= FAULT_NONE;
      addr_q    <= '0;
    end else if (reset_clear_i) begin
      latched_q <= 1'b0;
      cause_q   <= FAULT_NONE;
      addr_q    <= '0;
    end else if (fault && !latched_q) begin
      latched_q <= 1'b1;
      cause_q   <= fault_cause;
      addr_q    <= fault_addr;
    end
  end

  assign irq_o         = latched_q;
  assign reset_req_o   = latched_q;
  assign fault_cause_o = cause_q;
  assign fault_addr_o  = addr_q;

endmodule

// ==== verification/write_guard_tb.sv ====
`timescale 1ns/1ps
`include "wg_params.svh"

module write_guard_tb;
  import wg_axi_pkg::*;
  import wg_guard_pkg::*;

  localparam int BudgetAw   = 8;
  localparam int BeatBudget = 4;
  localparam int BudgetB    = 12;

  logic         clk_i;
  logic         rst_ni;
  logic         aw_valid_i, aw_ready_i;
  axi_id_t      aw_id_i;
  axi_addr_t    aw_addr_i;
  axi_len_t     aw_len_i;
  logic         w_valid_i, w_ready_i, w_last_i;
  logic         b_valid_i, b_ready_i;
  axi_id_t      b_id_i;
  cnt_t         budget_aw_i, budget_w_beat_i, budget_b_i;
  logic         reset_clear_i;
  logic         irq_o, reset_req_o;
  fault_cause_e fault_cause_o;
  axi_addr_t    fault_addr_o;

  // Expected fault record and checking windows
  int           seed;
  int           cyc;
  int           lat_start;
  int           min_lat;
  logic         timing_chk;
  logic         irq_allowed;
  logic         irq_hold;
  fault_cause_e exp_cause;
  axi_addr_t    exp_addr;

  write_guard i_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  initial cyc = 0;
  always @(posedge clk_i) cyc <= cyc + 1;

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopping at first error");
  endtask

  task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
    fail_run($sformatf("Mismatch at %0t: %s is %0h, expected %0h", $time, name, got, exp));
  endtask

  // Interrupt and reset request stay low outside an expected fault
  assert property (@(posedge clk_i) disable iff (!rst_ni) !irq_allowed |-> !irq_o)
    else mismatch("irq_o", $sampled(irq_o), 0);

  assert property (@(posedge clk_i) disable iff (!rst_ni) !irq_allowed |-> !reset_req_o)
    else mismatch("reset_req_o", $sampled(reset_req_o), 0);

  assert property (@(posedge clk_i) disable iff (!rst_ni) irq_hold |-> irq_o)
    else mismatch("irq_o", $sampled(irq_o), 1);

  assert property (@(posedge clk_i) disable iff (!rst_ni) irq_hold |-> reset_req_o)
    else mismatch("reset_req_o", $sampled(reset_req_o), 1);

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !irq_o |-> (fault_cause_o == FAULT_NONE))
    else mismatch("fault_cause_o", $sampled(fault_cause_o), FAULT_NONE);

  assert property (@(posedge clk_i) disable iff (!rst_ni) irq_o |-> (fault_cause_o == exp_cause))
    else mismatch("fault_cause_o", $sampled(fault_cause_o), $sampled(exp_cause));

  assert property (@(posedge clk_i) disable iff (!rst_ni) irq_o |-> (fault_addr_o == exp_addr))
    else mismatch("fault_addr_o", $sampled(fault_addr_o), $sampled(exp_addr));

  // Latch rises within three cycles of the budget running out
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (($rose(irq_o) || $rose(reset_req_o)) && timing_chk) |->
      ((cyc - lat_start) >= min_lat) && ((cyc - lat_start) <= min_lat + 3))
    else fail_run($sformatf("fault outputs rose %0d cycles after the fault began, expected %0d to %0d",
                            $sampled(cyc) - $sampled(lat_start), min_lat, min_lat + 3));

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    reset_clear_i |=> (!irq_o && !reset_req_o))
    else fail_run("irq_o or reset_req_o still high one cycle after the clear pulse");

  function automatic int rand_delay();
    return $unsigned($random(seed)) % 2;
  endfunction

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge clk_i);
  endtask

  task automatic send_aw(input axi_id_t id, input axi_addr_t addr, input axi_len_t len);
    aw_valid_i = 1'b1;
    aw_ready_i = 1'b1;
    aw_id_i    = id;
    aw_addr_i  = addr;
    aw_len_i   = len;
    @(negedge clk_i);
    aw_valid_i = 1'b0;
    aw_ready_i = 1'b0;
  endtask

  task automatic send_w(input int len, input bit gaps);
    for (int b = 0; b <= len; b++) begin
      if (gaps) idle_cycles(rand_delay());
      w_valid_i = 1'b1;
      w_ready_i = 1'b1;
      w_last_i  = (b == len);
      @(negedge clk_i);
      w_valid_i = 1'b0;
      w_ready_i = 1'b0;
      w_last_i  = 1'b0;
    end
  endtask

  task automatic send_b(input axi_id_t id);
    b_valid_i = 1'b1;
    b_ready_i = 1'b1;
    b_id_i    = id;
    @(negedge clk_i);
    b_valid_i = 1'b0;
    b_ready_i = 1'b0;
  endtask

  task automatic expect_fault(input fault_cause_e cause, input axi_addr_t addr, input int lat);
    exp_cause   = cause;
    exp_addr    = addr;
    min_lat     = lat;
    lat_start   = cyc;
    timing_chk  = 1'b1;
    irq_allowed = 1'b1;
  endtask

  task automatic wait_for_irq(input int max_cycles, input string what);
    int n;
    n = 0;
    while (!irq_o && (n < max_cycles)) begin
      @(negedge clk_i);
      n++;
    end
    if (!irq_o) fail_run($sformatf("no interrupt within %0d cycles for %s", max_cycles, what));
  endtask

  // Keep the latch under watch for a while, then clear it
  task automatic clear_fault(input int hold);
    irq_hold = 1'b1;
    idle_cycles(hold);
    irq_hold      = 1'b0;
    reset_clear_i = 1'b1;
    @(negedge clk_i);
    reset_clear_i = 1'b0;
    @(negedge clk_i);
    irq_allowed = 1'b0;
    timing_chk  = 1'b0;
  endtask

  initial begin
    seed = 32'he5988a4b;
    {aw_valid_i, aw_ready_i, w_valid_i, w_ready_i, w_last_i} = '0;
    {b_valid_i, b_ready_i, reset_clear_i} = '0;
    aw_id_i = '0;
    aw_addr_i = '0;
    aw_len_i = '0;
    b_id_i = '0;
    budget_aw_i     = cnt_t'(BudgetAw);
    budget_w_beat_i = cnt_t'(BeatBudget);
    budget_b_i      = cnt_t'(BudgetB);
    {timing_chk, irq_allowed, irq_hold} = '0;
    exp_cause = FAULT_NONE;
    exp_addr  = '0;
    min_lat   = 0;
    lat_start = 0;
    rst_ni    = 1'b0;
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);

    // Legal traffic with B out of order across IDs and in order within one ID
    for (int r = 0; r < 3; r++) begin
      idle_cycles(rand_delay());
      send_aw(1, axi_addr_t'('h1000 + r * 'h100), 1);
      send_w(1, 1'b1);
      idle_cycles(rand_delay());
      send_aw(2, axi_addr_t'('h1040 + r * 'h100), 0);
      send_w(0, 1'b1);
      idle_cycles(rand_delay());
      send_b(2);
      idle_cycles(rand_delay());
      send_b(1);
      idle_cycles(rand_delay());
      send_aw(3, axi_addr_t'('h1080 + r * 'h100), 2);
      send_w(2, 1'b1);
      idle_cycles(rand_delay());
      send_aw(3, axi_addr_t'('h10c0 + r * 'h100), 0);
      send_w(0, 1'b1);
      idle_cycles(rand_delay());
      send_b(3);
      idle_cycles(rand_delay());
      send_b(3);
    end
    idle_cycles(2 * BudgetB);

    // AW held without ready
    expect_fault(FAULT_AW_STALL, 'h2000, BudgetAw);
    aw_valid_i = 1'b1;
    aw_addr_i  = 'h2000;
    wait_for_irq(BudgetAw + 6, "AW stall");
    aw_valid_i = 1'b0;
    clear_fault(3);

    // Burst of three beats that never sends data
    expect_fault(FAULT_W_TIMEOUT, 'h3000, BeatBudget * 3);
    send_aw(4, 'h3000, 2);
    wait_for_irq(BeatBudget * 3 + 6, "W timeout");
    clear_fault(3);

    // Finished burst without a response
    send_aw(6, 'h4000, 0);
    expect_fault(FAULT_B_TIMEOUT, 'h4000, BudgetB);
    send_w(0, 1'b0);
    wait_for_irq(BudgetB + 6, "B timeout");
    clear_fault(3);

    expect_fault(FAULT_UNWANTED_B, '0, 0);
    send_b(9);
    wait_for_irq(6, "unwanted B");
    clear_fault(3);

    // One AW more than there are slots
    // Later W timeouts must not replace the cause
    for (int i = 0; i < `WG_MAX_TXNS; i++) begin
      send_aw(axi_id_t'(i), axi_addr_t'('h5000 + i * 'h10), 3);
    end
    expect_fault(FAULT_TABLE_FULL, axi_addr_t'('h5000 + `WG_MAX_TXNS * 'h10), 0);
    send_aw(axi_id_t'(`WG_MAX_TXNS), axi_addr_t'('h5000 + `WG_MAX_TXNS * 'h10), 3);
    wait_for_irq(6, "table overflow");
    clear_fault(BeatBudget * 4 + 10);

    idle_cycles(4);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// ==== write_guard.f ====
+incdir+rtl
rtl/wg_axi_pkg.sv
rtl/wg_guard_pkg.sv
rtl/wg_slot_if.sv
rtl/wg_id_queue.sv
rtl/wg_w_order_fifo.sv
rtl/wg_slot_tracker.sv
rtl/write_guard.sv
verification/write_guard_tb.sv

// ==== Bender.yml ====
package:
  name: write_guard

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/wg_axi_pkg.sv
      - rtl/wg_guard_pkg.sv
      - rtl/wg_slot_if.sv
      - rtl/wg_id_queue.sv
      - rtl/wg_w_order_fifo.sv
      - rtl/wg_slot_tracker.sv
      - rtl/write_guard.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verification/write_guard_tb.sv
